// ==== design/exp_ctrl.sv ====
/* exponentiation FSM: Montgomery conversion, exponent bit scan,
   square-and-multiply over c_bar and m_bar, serial result readout */
`timescale 1ns/1ps

module exp_ctrl #(
    parameter int NUM_WORDS = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         start_input,
    input  logic                                         start_compute,
    input  logic                                         get_result,
    input  logic                                         load_done,
    input  logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] m_full,
    input  logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] e_full,
    input  logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] r_full,
    input  logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] t_full,
    input  logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] product,
    input  logic                                         mont_done,
    output logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] a_full,
    output logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] b_full,
    output logic                                         mont_start,
    output logic                                         result_ready,
    output logic                                         res_valid,
    output modexp_pkg::word_t                            res_word
);

    localparam int W  = modexp_pkg::WORD_WIDTH;
    localparam int FW = NUM_WORDS * W;
    localparam int CW = $clog2(NUM_WORDS);
    localparam int BW = $clog2(FW);
    localparam logic [CW-1:0] LAST    = CW'(NUM_WORDS - 1);
    localparam logic [BW-1:0] TOP_BIT = BW'(FW - 1);

    modexp_pkg::exp_state_e state;
    modexp_pkg::mont_op_e   op;
    logic [FW-1:0]          c_bar;
    logic [FW-1:0]          m_bar;
    logic [BW-1:0]          bit_idx;    // exponent bit under test
    logic [CW-1:0]          out_idx;
    logic                   bit_set;
    logic                   last_bit;
    logic                   readout_shift;

    assign bit_set       = e_full[bit_idx];
    assign last_bit      = bit_idx == '0;
    assign result_ready  = state == modexp_pkg::st_complete;
    assign readout_shift = (result_ready && get_result) || state == modexp_pkg::st_output;

    always_comb begin
        case (op)
            modexp_pkg::op_to_mont: begin
                a_full = m_full;
                b_full = t_full;
            end
            modexp_pkg::op_square: begin
                a_full = c_bar;
                b_full = c_bar;
            end
            modexp_pkg::op_mul: begin
                a_full = c_bar;
                b_full = m_bar;
            end
            default: begin
                a_full = c_bar;
                b_full = FW'(1);    // leaves Montgomery form
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= modexp_pkg::st_idle;
            op         <= modexp_pkg::op_to_mont;
            bit_idx    <= '0;
            out_idx    <= '0;
            mont_start <= 1'b0;
            res_valid  <= 1'b0;
            res_word   <= '0;
        end else begin
            mont_start <= 1'b0;
            case (state)
                modexp_pkg::st_idle:
                    if (start_input)
                        state <= modexp_pkg::st_load;
                modexp_pkg::st_load:
                    if (load_done)
                        state <= modexp_pkg::st_wait;
                modexp_pkg::st_wait:
                    if (start_compute) begin
                        state      <= modexp_pkg::st_to_mont;
                        op         <= modexp_pkg::op_to_mont;
                        mont_start <= 1'b1;
                    end
                modexp_pkg::st_to_mont:
                    if (mont_done) begin
                        state   <= modexp_pkg::st_scan;
                        bit_idx <= TOP_BIT;
                    end
                modexp_pkg::st_scan:    // look for the leftmost one
                    if (bit_set) begin
                        state      <= modexp_pkg::st_square;
                        op         <= modexp_pkg::op_square;
                        mont_start <= 1'b1;
                    end else if (last_bit) begin
                        state      <= modexp_pkg::st_from_mont;  // e == 0, c_bar stays R mod n
                        op         <= modexp_pkg::op_from_mont;
                        mont_start <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                modexp_pkg::st_square:
                    if (mont_done) begin
                        mont_start <= 1'b1;
                        if (bit_set) begin
                            state <= modexp_pkg::st_mul;
                            op    <= modexp_pkg::op_mul;
                        end else if (last_bit) begin
                            state <= modexp_pkg::st_from_mont;
                            op    <= modexp_pkg::op_from_mont;
                        end else begin
                            bit_idx <= bit_idx - 1'b1;
                            op      <= modexp_pkg::op_square;
                        end
                    end
                modexp_pkg::st_mul:
                    if (mont_done) begin
                        mont_start <= 1'b1;
                        if (last_bit) begin
                            state <= modexp_pkg::st_from_mont;
                            op    <= modexp_pkg::op_from_mont;
                        end else begin
                            bit_idx <= bit_idx - 1'b1;
                            state   <= modexp_pkg::st_square;
                            op      <= modexp_pkg::op_square;
                        end
                    end
                modexp_pkg::st_from_mont:
                    if (mont_done)
                        state <= modexp_pkg::st_complete;
                modexp_pkg::st_complete:
                    if (get_result) begin
                        state     <= modexp_pkg::st_output;
                        out_idx   <= '0;
                        res_valid <= 1'b1;
                        res_word  <= c_bar[W-1:0];
                    end
                modexp_pkg::st_output:
                    if (out_idx == LAST) begin
                        state     <= modexp_pkg::st_idle;
                        res_valid <= 1'b0;
                        res_word  <= '0;
                    end else begin
                        out_idx  <= out_idx + 1'b1;
                        res_word <= c_bar[W-1:0];   // already shifted down
                    end
                default: state <= modexp_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mont_done) begin
            if (state == modexp_pkg::st_to_mont) begin
                m_bar <= product;
                c_bar <= r_full;    // Montgomery form of 1
            end else begin
                c_bar <= product;
            end
        end else if (readout_shift) begin
            c_bar <= c_bar >> W;
        end
    end

    // a product may only complete while the FSM is waiting for one
    assert property (@(posedge clk) disable iff (reset)
        mont_done |-> (state == modexp_pkg::st_to_mont || state == modexp_pkg::st_square ||
                       state == modexp_pkg::st_mul || state == modexp_pkg::st_from_mont))
        else $error("mont_done with no product outstanding");

endmodule

// ==== design/modexp.sv ====
/* modular exponentiator top: operand loader, exponent controller,
   Montgomery multiplier */
`timescale 1ns/1ps

module modexp #(
    parameter int NUM_WORDS = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start_input,
    input  logic                      start_compute,
    input  logic                      get_result,
    input  modexp_pkg::operand_word_t operand_in,
    input  modexp_pkg::word_t         nprime0,
    output logic                      result_ready,
    output logic                      res_valid,
    output modexp_pkg::word_t         res_word
);

    localparam int FW = NUM_WORDS * modexp_pkg::WORD_WIDTH;

    logic [FW-1:0] m_full;
    logic [FW-1:0] e_full;
    logic [FW-1:0] n_full;
    logic [FW-1:0] r_full;
    logic [FW-1:0] t_full;
    logic [FW-1:0] a_full;
    logic [FW-1:0] b_full;
    logic [FW-1:0] product;
    logic          load_done;
    logic          mont_start;
    logic          mont_done;

    operand_loader #(.NUM_WORDS(NUM_WORDS)) i_loader (
        .clk         (clk),
        .reset       (reset),
        .start_input (start_input),
        .operand_in  (operand_in),
        .m_full      (m_full),
        .e_full      (e_full),
        .n_full      (n_full),
        .r_full      (r_full),
        .t_full      (t_full),
        .load_done   (load_done)
    );

    exp_ctrl #(.NUM_WORDS(NUM_WORDS)) i_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start_input   (start_input),
        .start_compute (start_compute),
        .get_result    (get_result),
        .load_done     (load_done),
        .m_full        (m_full),
        .e_full        (e_full),
        .r_full        (r_full),
        .t_full        (t_full),
        .product       (product),
        .mont_done     (mont_done),
        .a_full        (a_full),
        .b_full        (b_full),
        .mont_start    (mont_start),
        .result_ready  (result_ready),
        .res_valid     (res_valid),
        .res_word      (res_word)
    );

    mont_mul #(.NUM_WORDS(NUM_WORDS)) i_mont (
        .clk        (clk),
        .reset      (reset),
        .mont_start (mont_start),
        .a_full     (a_full),
        .b_full     (b_full),
        .n_full     (n_full),
        .nprime0    (nprime0),
        .product    (product),
        .mont_done  (mont_done)
    );

endmodule

// ==== design/modexp_pkg.sv ====
/* word type, per-cycle operand struct, Montgomery product and
   controller state enums for the modular exponentiator */
package modexp_pkg;

    localparam int WORD_WIDTH = 16;

    typedef logic [WORD_WIDTH-1:0] word_t;

    // one word of every operand, sent together during the serial load
    typedef struct packed {
        word_t m;
        word_t e;
        word_t n;
        word_t r;   // R mod n
        word_t t;   // R^2 mod n
    } operand_word_t;

    typedef enum logic [1:0] {
        op_to_mont,     // m * t
        op_square,      // c_bar * c_bar
        op_mul,         // c_bar * m_bar
        op_from_mont    // c_bar * 1
    } mont_op_e;

    typedef enum logic [3:0] {
        st_idle,
        st_load,
        st_wait,
        st_to_mont,
        st_scan,
        st_square,
        st_mul,
        st_from_mont,
        st_complete,
        st_output
    } exp_state_e;

endpackage

// ==== design/mont_mul.sv ====
/* word-serial CIOS Montgomery multiply, product = a * b * R^-1 mod n,
   sequenced over one shared mul_add in issue/capture pairs */
`timescale 1ns/1ps

module mont_mul #(
    parameter int NUM_WORDS = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         mont_start,
    input  logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] a_full,
    input  logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] b_full,
    input  logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] n_full,
    input  modexp_pkg::word_t                            nprime0,
    output logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] product,
    output logic                                         mont_done
);

    localparam int W  = modexp_pkg::WORD_WIDTH;
    localparam int CW = $clog2(NUM_WORDS);
    localparam logic [CW-1:0] LAST = CW'(NUM_WORDS - 1);

    typedef enum logic [2:0] {
        s_mul,      // v += a[i] * b
        s_fold,     // spread top carry into v[N], v[N+1]
        s_red,      // red_m = v[0] * nprime0
        s_sub,      // v = (v + red_m * n) >> W
        s_top,      // v[N-1] = v[N] + carry
        s_carry     // v[N] = v[N+1] + carry
    } step_e;

    step_e             step;
    logic              busy;
    logic              capture;     // second cycle of a step
    logic [CW-1:0]     i;
    logic [CW-1:0]     j;
    modexp_pkg::word_t v [NUM_WORDS+2];
    modexp_pkg::word_t carry;
    modexp_pkg::word_t red_m;
    modexp_pkg::word_t x;
    modexp_pkg::word_t y;
    modexp_pkg::word_t z;
    modexp_pkg::word_t carry_in;
    modexp_pkg::word_t sum;
    modexp_pkg::word_t carry_out;
    logic              finish;

    mul_add i_mul_add (
        .clk       (clk),
        .x         (x),
        .y         (y),
        .z         (z),
        .carry_in  (carry_in),
        .sum       (sum),
        .carry_out (carry_out)
    );

    // operands for the step being issued
    always_comb begin
        x        = '0;
        y        = '0;
        z        = '0;
        carry_in = carry;
        case (step)
            s_mul: begin
                x = a_full[i*W +: W];
                y = b_full[j*W +: W];
                z = v[j];
                if (j == '0)
                    carry_in = '0;  // inner loop starts with C = 0
            end
            s_fold:  z = v[NUM_WORDS];
            s_red: begin
                x        = v[0];
                y        = nprime0;
                carry_in = '0;
            end
            s_sub: begin
                x = red_m;
                y = n_full[j*W +: W];
                z = v[j];
                if (j == '0)
                    carry_in = '0;
            end
            s_top:   z = v[NUM_WORDS];
            s_carry: z = v[NUM_WORDS+1];
            default: ;
        endcase
    end

    assign finish = busy && capture && step == s_carry && i == LAST;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            capture   <= 1'b0;
            step      <= s_mul;
            i         <= '0;
            j         <= '0;
            carry     <= '0;
            red_m     <= '0;
            mont_done <= 1'b0;
            for (int k = 0; k < NUM_WORDS + 2; k++)
                v[k] <= '0;
        end else begin
            mont_done <= 1'b0;
            if (!busy) begin
                if (mont_start) begin
                    busy    <= 1'b1;
                    capture <= 1'b0;
                    step    <= s_mul;
                    i       <= '0;
                    j       <= '0;
                end
            end else if (!capture) begin
                capture <= 1'b1;    // mul_add holds the operands now
            end else begin
                capture <= 1'b0;
                case (step)
                    s_mul: begin
                        v[j]  <= sum;
                        carry <= carry_out;
                        if (j == LAST) begin
                            j    <= '0;
                            step <= s_fold;
                        end else begin
                            j <= j + 1'b1;
                        end
                    end
                    s_fold: begin
                        v[NUM_WORDS]   <= sum;
                        v[NUM_WORDS+1] <= carry_out;
                        step           <= s_red;
                    end
                    s_red: begin
                        red_m <= sum;
                        step  <= s_sub;
                    end
                    s_sub: begin
                        if (j != '0)
                            v[j-1'b1] <= sum;   // word 0 is zero by choice of red_m
                        carry <= carry_out;
                        if (j == LAST) begin
                            j    <= '0;
                            step <= s_top;
                        end else begin
                            j <= j + 1'b1;
                        end
                    end
                    s_top: begin
                        v[NUM_WORDS-1] <= sum;
                        carry          <= carry_out;
                        step           <= s_carry;
                    end
                    s_carry: begin
                        step <= s_mul;
                        if (i == LAST) begin
                            busy      <= 1'b0;
                            mont_done <= 1'b1;
                            i         <= '0;
                            for (int k = 0; k < NUM_WORDS + 2; k++)
                                v[k] <= '0;     // ready for the next product
                        end else begin
                            v[NUM_WORDS] <= sum;
                            i            <= i + 1'b1;
                        end
                    end
                    default: step <= s_mul;
                endcase
            end
        end
    end

    // low words are final once s_top has run in the last outer pass
    always_ff @(posedge clk) begin
        if (finish) begin
            for (int k = 0; k < NUM_WORDS; k++)
                product[k*W +: W] <= v[k];
        end
    end

    // the controller keeps one product in flight at a time
    assert property (@(posedge clk) disable iff (reset) busy |-> !mont_start)
        else $error("mont_start while a product is in progress");

endmodule

// ==== design/mul_add.sv ====
/* registered word multiply-add, (carry_out, sum) = x * y + z + carry_in */
`timescale 1ns/1ps

module mul_add (
    input  logic              clk,
    input  modexp_pkg::word_t x,
    input  modexp_pkg::word_t y,
    input  modexp_pkg::word_t z,
    input  modexp_pkg::word_t carry_in,
    output modexp_pkg::word_t sum,
    output modexp_pkg::word_t carry_out
);

    localparam int W = modexp_pkg::WORD_WIDTH;

    logic [2*W-1:0] result;

    // max value is exactly 2^(2W) - 1, never overflows
    assign result = (2*W)'(x) * (2*W)'(y) + (2*W)'(z) + (2*W)'(carry_in);

    always_ff @(posedge clk) begin
        sum       <= result[W-1:0];
        carry_out <= result[2*W-1:W];
    end

endmodule

// ==== design/operand_loader.sv ====
/* serial load of m, e, n, r and t, one word per cycle, lsw first */
`timescale 1ns/1ps

module operand_loader #(
    parameter int NUM_WORDS = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         start_input,
    input  modexp_pkg::operand_word_t                    operand_in,
    output logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] m_full,
    output logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] e_full,
    output logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] n_full,
    output logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] r_full,
    output logic [NUM_WORDS*modexp_pkg::WORD_WIDTH-1:0] t_full,
    output logic                                         load_done
);

    localparam int W  = modexp_pkg::WORD_WIDTH;
    localparam int CW = $clog2(NUM_WORDS);
    localparam logic [CW-1:0] LAST = CW'(NUM_WORDS - 1);

    logic          loading;
    logic [CW-1:0] cnt;     // word slot being written

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loading   <= 1'b0;
            cnt       <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (!loading) begin
                if (start_input) begin
                    loading <= 1'b1;
                    cnt     <= '0;
                end
            end else if (cnt == LAST) begin
                loading   <= 1'b0;
                load_done <= 1'b1;  // seen by the controller next edge
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loading) begin
            m_full[cnt*W +: W] <= operand_in.m;
            e_full[cnt*W +: W] <= operand_in.e;
            n_full[cnt*W +: W] <= operand_in.n;
            r_full[cnt*W +: W] <= operand_in.r;
            t_full[cnt*W +: W] <= operand_in.t;
        end
    end

    // a new load must not restart one that is still filling the slots
    assert property (@(posedge clk) disable iff (reset) loading |-> !start_input)
        else $error("start_input while operands are still loading");

endmodule

// ==== modexp.f ====
+incdir+sim
design/modexp_pkg.sv
design/mul_add.sv
design/operand_loader.sv
design/mont_mul.sv
design/exp_ctrl.sv
design/modexp.sv
sim/clock_gen.sv
sim/tb_modexp.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the modexp testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f modexp.f --top-module tb_modexp \
    -Mdir obj_dir -o sim_modexp
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_modexp
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// ==== sim/clock_gen.sv ====
/* testbench clock and reset source, 8 ns period, reset for 3 cycles */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk) reset = 1'b0;    // released away from the sampling edge
    end

endmodule

// ==== sim/modexp_ref.svh ====
/* reference model for 64-bit operands: m^e mod n, R mod n,
   R^2 mod n and the negated inverse of n modulo 2^16 */
`ifndef MODEXP_REF_SVH
`define MODEXP_REF_SVH

// left-to-right square-and-multiply, operands stay below 2^62
function automatic logic [63:0] modexp_model(input logic [63:0] m, input logic [63:0] e,
                                             input logic [63:0] n);
    logic [127:0] acc;
    logic [127:0] base;
    logic [127:0] modulus;
    modulus = {64'd0, n};
    base    = {64'd0, m} % modulus;
    acc     = 128'd1 % modulus;
    for (int b = 63; b >= 0; b--) begin
        acc = (acc * acc) % modulus;
        if (e[b])
            acc = (acc * base) % modulus;
    end
    return acc[63:0];
endfunction

function automatic logic [63:0] r_mod_n(input logic [63:0] n);
    logic [127:0] r;
    r = (128'd1 << 64) % {64'd0, n};    // R = 2^64
    return r[63:0];
endfunction

function automatic logic [63:0] r2_mod_n(input logic [63:0] n);
    logic [127:0] r;
    logic [127:0] t;
    r = {64'd0, r_mod_n(n)};
    t = (r * r) % {64'd0, n};   // (R mod n)^2 mod n == R^2 mod n
    return t[63:0];
endfunction

function automatic modexp_pkg::word_t nprime0_value(input logic [63:0] n);
    logic [15:0] n0;
    logic [15:0] inv;
    n0  = n[15:0];
    inv = n0;   // good to 3 bits for odd n
    for (int k = 0; k < 4; k++)
        inv = inv * (16'd2 - n0 * inv);     // Newton step doubles the good bits
    return 16'd0 - inv;
endfunction

`endif

// ==== sim/tb_modexp.sv ====
/* testbench for the modular exponentiator: table of operand sets run
   through serial load, compute and readout, words checked against a model */
`timescale 1ns/1ps

module tb_modexp;

    localparam int NUM_WORDS  = 4;
    localparam int W          = modexp_pkg::WORD_WIDTH;
    localparam int TIMEOUT    = 20000;  // cycles, a full 64-bit e needs about 12600
    localparam int NUM_RANDOM = 4;

    typedef struct packed {
        logic [63:0] m;
        logic [63:0] e;
        logic [63:0] n;
        logic [63:0] expected;
    } test_case_t;

    logic                      clk;
    logic                      reset;
    logic                      start_input;
    logic                      start_compute;
    logic                      get_result;
    modexp_pkg::operand_word_t operand_in;
    modexp_pkg::word_t         nprime0;
    logic                      result_ready;
    logic                      res_valid;
    modexp_pkg::word_t         res_word;

    test_case_t  cases[$];
    logic [31:0] lcg_state;

    `include "modexp_ref.svh"

    clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    modexp #(.NUM_WORDS(NUM_WORDS)) i_modexp (
        .clk           (clk),
        .reset         (reset),
        .start_input   (start_input),
        .start_compute (start_compute),
        .get_result    (get_result),
        .operand_in    (operand_in),
        .nprime0       (nprime0),
        .result_ready  (result_ready),
        .res_valid     (res_valid),
        .res_word      (res_word)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic test_case_t make_case(input logic [63:0] m, input logic [63:0] e,
                                             input logic [63:0] n, input logic [63:0] expected);
        return {m, e, n, expected};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic build_table();
        logic [63:0] m;
        logic [63:0] e;
        logic [63:0] n;
        logic [31:0] shift;
        cases.push_back(make_case(64'd4, 64'd13, 64'd497, 64'd445));
        cases.push_back(make_case(64'd5, 64'd3, 64'd13, 64'd8));
        cases.push_back(make_case(64'd12345, 64'd1, 64'h3fff_ffff_ffff_ffc5, 64'd12345));
        cases.push_back(make_case(64'h0123_4567_89ab_cdef, 64'd0, 64'h2fed_cba9_8765_4321, 64'd1));
        m = 64'h1234_5678_9abc_def1;
        n = 64'h3a5b_c7d9_e1f2_0317;
        e = 64'h0000_0000_0001_0003;    // scan crosses into word 1
        cases.push_back(make_case(m, e, n, modexp_model(m, e, n)));
        e = 64'h0000_0001_0000_0000;    // single one in word 2
        cases.push_back(make_case(m, e, n, modexp_model(m, e, n)));
        m = 64'h2468_ace0_1357_9bdf;
        n = 64'h3c3c_3c3c_3c3c_3c3d;
        e = '1;     // every bit squares and multiplies
        cases.push_back(make_case(m, e, n, modexp_model(m, e, n)));
        m = 64'h0fff_ffff_ffff_fffe;
        n = 64'h3fff_ffff_ffff_ffc5;
        e = 64'd2;
        cases.push_back(make_case(m, e, n, modexp_model(m, e, n)));
        for (int k = 0; k < NUM_RANDOM; k++) begin
            n = {lcg_next(), lcg_next()};
            n = (n & 64'h3fff_ffff_ffff_ffff) | 64'h2000_0000_0000_0001;   // odd, below R/4
            m = {lcg_next(), lcg_next()} % n;
            e = {lcg_next(), lcg_next()};
            shift = lcg_next();
            e = e >> shift[5:0];    // vary the exponent length
            cases.push_back(make_case(m, e, n, modexp_model(m, e, n)));
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20)
                report_failure("reset was never released");
        end
    endtask

    task automatic load_operands(input test_case_t tc);
        logic [63:0] r;
        logic [63:0] t;
        r = r_mod_n(tc.n);
        t = r2_mod_n(tc.n);
        @(negedge clk);
        start_input = 1'b1;
        nprime0     = nprime0_value(tc.n);
        for (int k = 0; k < NUM_WORDS; k++) begin
            @(negedge clk);
            start_input  = 1'b0;
            operand_in.m = tc.m[k*W +: W];  // lsw first
            operand_in.e = tc.e[k*W +: W];
            operand_in.n = tc.n[k*W +: W];
            operand_in.r = r[k*W +: W];
            operand_in.t = t[k*W +: W];
        end
        @(negedge clk);
        operand_in = '0;
    endtask

    task automatic start_computation();
        @(negedge clk);
        start_compute = 1'b1;   // controller reaches st_wait two edges after the last word
        @(negedge clk);
        start_compute = 1'b0;
    endtask

    task automatic wait_result_ready(input int idx);
        int cycles;
        cycles = 0;
        while (!result_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                report_failure($sformatf("case %0d timed out waiting for result_ready", idx));
        end
    endtask

    task automatic read_and_check(input test_case_t tc, input int idx);
        modexp_pkg::word_t want;
        @(negedge clk);
        get_result = 1'b1;
        for (int k = 0; k < NUM_WORDS; k++) begin
            @(negedge clk);
            get_result = 1'b0;
            want       = tc.expected[k*W +: W];
            assert (res_valid)
                else report_failure($sformatf("Mismatch at %0t: case %0d word %0d, res_valid low",
                    $time, idx, k));
            assert (res_word == want)
                else report_failure($sformatf("Mismatch at %0t: case %0d word %0d, got %h want %h",
                    $time, idx, k, res_word, want));
            if (k == 0) begin
                assert (!result_ready)
                    else report_failure($sformatf("Mismatch at %0t: case %0d, result_ready high",
                        $time, idx));
            end
        end
        @(negedge clk);
        assert (!res_valid && res_word == '0)
            else report_failure($sformatf("Mismatch at %0t: case %0d, readout longer than %0d",
                $time, idx, NUM_WORDS));
    endtask

    // get_result with no result pending must leave the outputs quiet
    task automatic check_stray_get_result();
        @(negedge clk);
        get_result = 1'b1;
        for (int k = 0; k <= NUM_WORDS; k++) begin
            @(negedge clk);
            get_result = 1'b0;
            assert (!res_valid && !result_ready && res_word == '0)
                else report_failure($sformatf("Mismatch at %0t: readout without a result",
                    $time));
        end
    endtask

    initial begin
        start_input   = 1'b0;
        start_compute = 1'b0;
        get_result    = 1'b0;
        operand_in    = '0;
        nprime0       = '0;
        lcg_state     = 32'hb7ac_674b;
        build_table();
        wait_reset_release();
        assert (!result_ready && !res_valid && res_word == '0)
            else report_failure($sformatf("Mismatch at %0t: outputs not idle after reset", $time));
        check_stray_get_result();
        foreach (cases[idx]) begin
            load_operands(cases[idx]);
            start_computation();
            wait_result_ready(idx);
            read_and_check(cases[idx], idx);
            check_stray_get_result();
        end
        $display("All tests passed");
        $finish;
    end

endmodule
